// ==== logic/mem_cfg_pkg.sv ====
//**************************************************
// Geometry of the banked unified memory
// Address field layout and bank interleave
// Flow-control credits and response FIFO sizing
//**************************************************

package mem_cfg_pkg;

   //**************************************************
   // Line and data port geometry
   //**************************************************
   localparam int LINE_BYTES     = 16;
   localparam int LINE_W         = LINE_BYTES * 8;
   localparam int DATA_W         = 64;
   localparam int OFFSET_W       = $clog2(LINE_BYTES);

   // Lines interleave across the banks
   localparam int BANKS          = 4;
   localparam int BANK_W         = $clog2(BANKS);
   localparam int LINES_PER_BANK = 64;
   localparam int INDEX_W        = $clog2(LINES_PER_BANK);

   //**************************************************
   // Byte address layout
   //**************************************************
   // Low to high: offset, bank, index
   localparam int ADDR_W         = OFFSET_W + BANK_W + INDEX_W;
   localparam int BANK_LSB       = OFFSET_W;
   localparam int INDEX_LSB      = OFFSET_W + BANK_W;

   //**************************************************
   // Credits per channel
   //**************************************************
   // Also the depth of each response FIFO
   localparam int CREDITS        = 4;
   localparam int FIFO_PTR_W     = $clog2(CREDITS);
   // Count must hold the full value CREDITS
   localparam int FIFO_CNT_W     = $clog2(CREDITS + 1);

endpackage

// ==== logic/mem_msg_pkg.sv ====
//**************************************************
// Message types of the banked memory
// Access size encoding
// Host requests and responses per channel
// Per-bank request message
//**************************************************

package mem_msg_pkg;
   import mem_cfg_pkg::*;

   // Access size, encoded as log2 of the byte count
   typedef enum logic [1:0] {
      SZ_BYTE   = 2'b00,
      SZ_HALF   = 2'b01,
      SZ_WORD   = 2'b10,
      SZ_DOUBLE = 2'b11
   } acc_size_t;

   //**************************************************
   // Host side
   //**************************************************
   // Line fetch, low address bits ignored
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } fetch_req_t;

   // Load or store, store data right-aligned
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      acc_size_t         size;
      logic              is_unsigned;
      logic              store;
      logic [DATA_W-1:0] wdata;
   } data_req_t;

   typedef struct packed {
      logic [LINE_W-1:0] line;
   } fetch_rsp_t;

   // Load result, zero on a store acknowledge
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              store_ack;
   } data_rsp_t;

   //**************************************************
   // Bank side
   //**************************************************
   // Offset already aligned down to the size
   typedef struct packed {
      logic [INDEX_W-1:0]    index;
      logic [OFFSET_W-1:0]   offset;
      acc_size_t             size;
      logic                  is_unsigned;
      logic                  store;
      logic [LINE_BYTES-1:0] be;
      logic [DATA_W-1:0]     wdata;
   } bank_req_t;

endpackage

// ==== logic/mem_req_router.sv ====
//**************************************************
// Request router
// Splits host addresses into bank, index, offset
// Builds store byte enables
// Registers one-hot bank issues per channel
//**************************************************

module mem_req_router
   import mem_cfg_pkg::*;
   import mem_msg_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              fetch_req_valid,
   input  fetch_req_t        fetch_req,
   input  logic              data_req_valid,
   input  data_req_t         data_req,
   output logic [BANKS-1:0]  fetch_issue,
   output logic [BANKS-1:0]  data_issue,
   output bank_req_t         fetch_bank_req,
   output bank_req_t         data_bank_req,
   output logic [BANK_W-1:0] fetch_bank,
   output logic [BANK_W-1:0] data_bank
);

   logic [BANK_W-1:0]     fetch_bank_d;
   logic [BANK_W-1:0]     data_bank_d;
   logic [OFFSET_W-1:0]   data_off;
   logic [OFFSET_W-1:0]   data_off_al;
   logic [LINE_BYTES-1:0] size_mask;
   bank_req_t             fetch_bank_req_d;
   bank_req_t             data_bank_req_d;

   //**************************************************
   // Address decode
   //**************************************************
   assign fetch_bank_d = fetch_req.addr[BANK_LSB +: BANK_W];
   assign data_bank_d  = data_req.addr[BANK_LSB +: BANK_W];
   assign data_off     = data_req.addr[OFFSET_W-1:0];

   // Misaligned data addresses drop to the size boundary
   always_comb begin
      case (data_req.size)
         SZ_BYTE: data_off_al = data_off;
         SZ_HALF: data_off_al = {data_off[OFFSET_W-1:1], 1'b0};
         SZ_WORD: data_off_al = {data_off[OFFSET_W-1:2], 2'b00};
         default: data_off_al = {data_off[OFFSET_W-1:3], 3'b000};
      endcase
   end

   // Enabled bytes before the shift to the offset
   always_comb begin
      case (data_req.size)
         SZ_BYTE: size_mask = LINE_BYTES'(8'h01);
         SZ_HALF: size_mask = LINE_BYTES'(8'h03);
         SZ_WORD: size_mask = LINE_BYTES'(8'h0f);
         default: size_mask = LINE_BYTES'(8'hff);
      endcase
   end

   //**************************************************
   // Bank messages
   //**************************************************
   always_comb begin
      // Fetch only needs the line index
      fetch_bank_req_d       = '0;
      fetch_bank_req_d.index = fetch_req.addr[INDEX_LSB +: INDEX_W];

      data_bank_req_d             = '0;
      data_bank_req_d.index       = data_req.addr[INDEX_LSB +: INDEX_W];
      data_bank_req_d.offset      = data_off_al;
      data_bank_req_d.size        = data_req.size;
      data_bank_req_d.is_unsigned = data_req.is_unsigned;
      data_bank_req_d.store       = data_req.store;
      data_bank_req_d.wdata       = data_req.wdata;
      // Loads write no bytes
      if (data_req.store) begin
         data_bank_req_d.be = size_mask << data_off_al;
      end
   end

   //**************************************************
   // Request register
   //**************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_issue <= '0;
         data_issue  <= '0;
      end else begin
         fetch_issue <= fetch_req_valid ? (BANKS'(1) << fetch_bank_d) : '0;
         data_issue  <= data_req_valid ? (BANKS'(1) << data_bank_d) : '0;
      end
   end

   // Payload only, qualified by the issue bits
   always_ff @(posedge clk) begin
      fetch_bank_req <= fetch_bank_req_d;
      data_bank_req  <= data_bank_req_d;
      fetch_bank     <= fetch_bank_d;
      data_bank      <= data_bank_d;
   end

endmodule

// ==== logic/mem_bank.sv ====
//**************************************************
// One memory bank
// Line read port for instruction fetch
// Byte-enabled data port with load extension
//**************************************************

module mem_bank
   import mem_cfg_pkg::*;
   import mem_msg_pkg::*;
(
   input  logic              clk,
   input  logic              fetch_issue,
   input  bank_req_t         fetch_req,
   input  logic              data_issue,
   input  bank_req_t         data_req,
   output logic [LINE_W-1:0] line,
   output data_rsp_t         data_rsp
);

   logic [LINE_W-1:0] mem [LINES_PER_BANK];

   logic [LINE_W-1:0] data_line;
   logic [LINE_W-1:0] wr_line;
   logic [LINE_W-1:0] rd_shift;
   logic [DATA_W-1:0] rd_raw;

   //**************************************************
   // Load extension
   //**************************************************
   // Sign bit is forced low for unsigned loads
   function automatic logic [DATA_W-1:0] extend_load(
      input logic [DATA_W-1:0] raw,
      input acc_size_t         size,
      input logic              is_unsigned
   );
      logic [DATA_W-1:0] res;
      case (size)
         SZ_BYTE:
            res = {{(DATA_W-8){~is_unsigned & raw[7]}}, raw[7:0]};
         SZ_HALF:
            res = {{(DATA_W-16){~is_unsigned & raw[15]}}, raw[15:0]};
         SZ_WORD:
            res = {{(DATA_W-32){~is_unsigned & raw[31]}}, raw[31:0]};
         default:
            res = raw;
      endcase
      return res;
   endfunction

   // Old contents, a same-cycle store lands after the read
   assign data_line = mem[data_req.index];

   // Store data moved to its byte offset
   assign wr_line = LINE_W'(data_req.wdata) << {data_req.offset, 3'b000};

   // Load field moved down to bit 0
   assign rd_shift = data_line >> {data_req.offset, 3'b000};
   assign rd_raw   = rd_shift[DATA_W-1:0];

   //**************************************************
   // Store port
   //**************************************************
   always_ff @(posedge clk) begin
      if (data_issue && data_req.store) begin
         for (int b = 0; b < LINE_BYTES; b++) begin
            if (data_req.be[b]) begin
               mem[data_req.index][b*8 +: 8] <= wr_line[b*8 +: 8];
            end
         end
      end
   end

   //**************************************************
   // Read ports
   //**************************************************
   // Full line for fetch
   always_ff @(posedge clk) begin
      if (fetch_issue) begin
         line <= mem[fetch_req.index];
      end
   end

   // Load result or store acknowledge
   always_ff @(posedge clk) begin
      if (data_issue) begin
         if (data_req.store) begin
            data_rsp.rdata     <= '0;
            data_rsp.store_ack <= 1'b1;
         end else begin
            data_rsp.rdata     <= extend_load(rd_raw, data_req.size, data_req.is_unsigned);
            data_rsp.store_ack <= 1'b0;
         end
      end
   end

endmodule

// ==== logic/rsp_fifo.sv ====
//**************************************************
// Response FIFO, CREDITS entries deep
// Payload given by a type parameter
// Head visible while valid is high
//**************************************************

module rsp_fifo
   import mem_cfg_pkg::*;
#(
   parameter type payload_t = logic [DATA_W-1:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t din,
   input  logic     pop,
   output payload_t dout,
   output logic     valid
);

   payload_t              buf_q [CREDITS];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;
   logic                  do_pop;

   // Credits keep push away from a full FIFO
   assign do_pop = pop && valid;
   assign valid  = (count != '0);
   assign dout   = buf_q[rd_ptr];

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         buf_q[wr_ptr] <= din;
      end
   end

   //**************************************************
   // Pointers and occupancy
   //**************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == FIFO_PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == FIFO_PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop keeps the count
         if (push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== logic/mem_rsp_merge.sv ====
//**************************************************
// Response merger
// Picks the responding bank per channel
// Queues responses and returns credits on take
//**************************************************

module mem_rsp_merge
   import mem_cfg_pkg::*;
   import mem_msg_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [BANKS-1:0]  fetch_issue,
   input  logic [BANKS-1:0]  data_issue,
   input  logic [BANK_W-1:0] fetch_bank,
   input  logic [BANK_W-1:0] data_bank,
   input  logic [LINE_W-1:0] lines [BANKS],
   input  data_rsp_t         data_rsps [BANKS],
   input  logic              fetch_take,
   input  logic              data_take,
   output fetch_rsp_t        fetch_rsp,
   output logic              fetch_rsp_valid,
   output data_rsp_t         data_rsp,
   output logic              data_rsp_valid,
   output logic              fetch_credit,
   output logic              data_credit
);

   logic              fetch_push;
   logic              data_push;
   logic [BANK_W-1:0] fetch_bank_q;
   logic [BANK_W-1:0] data_bank_q;
   fetch_rsp_t        fetch_din;
   data_rsp_t         data_din;

   //**************************************************
   // Align with the bank read cycle
   //**************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_push <= 1'b0;
         data_push  <= 1'b0;
      end else begin
         fetch_push <= |fetch_issue;
         data_push  <= |data_issue;
      end
   end

   // Bank numbers only matter with a push
   always_ff @(posedge clk) begin
      fetch_bank_q <= fetch_bank;
      data_bank_q  <= data_bank;
   end

   // Output of the bank that was issued
   assign fetch_din = '{line: lines[fetch_bank_q]};
   assign data_din  = data_rsps[data_bank_q];

   //**************************************************
   // Per-channel queues
   //**************************************************
   rsp_fifo #(
      .payload_t (fetch_rsp_t)
   ) i_fetch_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (fetch_push),
      .din   (fetch_din),
      .pop   (fetch_take),
      .dout  (fetch_rsp),
      .valid (fetch_rsp_valid)
   );

   rsp_fifo #(
      .payload_t (data_rsp_t)
   ) i_data_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (data_push),
      .din   (data_din),
      .pop   (data_take),
      .dout  (data_rsp),
      .valid (data_rsp_valid)
   );

   // One credit per accepted take, a cycle later
   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_credit <= 1'b0;
         data_credit  <= 1'b0;
      end else begin
         fetch_credit <= fetch_take && fetch_rsp_valid;
         data_credit  <= data_take && data_rsp_valid;
      end
   end

endmodule

// ==== logic/banked_mem_top.sv ====
//**************************************************
// Banked unified memory, top level
// Router, four interleaved banks, response merger
//**************************************************

module banked_mem_top
   import mem_cfg_pkg::*;
   import mem_msg_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       fetch_req_valid,
   input  fetch_req_t fetch_req,
   input  logic       data_req_valid,
   input  data_req_t  data_req,
   output logic       fetch_rsp_valid,
   output fetch_rsp_t fetch_rsp,
   output logic       data_rsp_valid,
   output data_rsp_t  data_rsp,
   input  logic       fetch_take,
   input  logic       data_take,
   output logic       fetch_credit,
   output logic       data_credit
);

   logic [BANKS-1:0]  fetch_issue;
   logic [BANKS-1:0]  data_issue;
   bank_req_t         fetch_bank_req;
   bank_req_t         data_bank_req;
   logic [BANK_W-1:0] fetch_bank;
   logic [BANK_W-1:0] data_bank;
   logic [LINE_W-1:0] lines [BANKS];
   data_rsp_t         data_rsps [BANKS];

   mem_req_router i_router (
      .clk             (clk),
      .rst             (rst),
      .fetch_req_valid (fetch_req_valid),
      .fetch_req       (fetch_req),
      .data_req_valid  (data_req_valid),
      .data_req        (data_req),
      .fetch_issue     (fetch_issue),
      .data_issue      (data_issue),
      .fetch_bank_req  (fetch_bank_req),
      .data_bank_req   (data_bank_req),
      .fetch_bank      (fetch_bank),
      .data_bank       (data_bank)
   );

   // Bank array, requests shared and gated by issue bits
   for (genvar b = 0; b < BANKS; b++) begin : g_bank
      mem_bank i_bank (
         .clk         (clk),
         .fetch_issue (fetch_issue[b]),
         .fetch_req   (fetch_bank_req),
         .data_issue  (data_issue[b]),
         .data_req    (data_bank_req),
         .line        (lines[b]),
         .data_rsp    (data_rsps[b])
      );
   end

   mem_rsp_merge i_merge (
      .clk             (clk),
      .rst             (rst),
      .fetch_issue     (fetch_issue),
      .data_issue      (data_issue),
      .fetch_bank      (fetch_bank),
      .data_bank       (data_bank),
      .lines           (lines),
      .data_rsps       (data_rsps),
      .fetch_take      (fetch_take),
      .data_take       (data_take),
      .fetch_rsp       (fetch_rsp),
      .fetch_rsp_valid (fetch_rsp_valid),
      .data_rsp        (data_rsp),
      .data_rsp_valid  (data_rsp_valid),
      .fetch_credit    (fetch_credit),
      .data_credit     (data_credit)
   );

endmodule

// ==== test/banked_mem_tb.sv ====
//**************************************************
// Testbench for the banked unified memory
// Byte-array reference model and credit bookkeeping
// Directed tests for stores, fetches and load extension
// plus concurrent channels, credits and response latency
//**************************************************

module banked_mem_tb
   import mem_cfg_pkg::*;
   import mem_msg_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT = 50;

   logic       clk;
   logic       rst;
   logic       fetch_req_valid;
   fetch_req_t fetch_req;
   logic       data_req_valid;
   data_req_t  data_req;
   logic       fetch_rsp_valid;
   fetch_rsp_t fetch_rsp;
   logic       data_rsp_valid;
   data_rsp_t  data_rsp;
   logic       fetch_take;
   logic       data_take;
   logic       fetch_credit;
   logic       data_credit;

   // Reference memory with one entry per byte address
   logic [7:0] model [1 << ADDR_W];
   fetch_rsp_t exp_fetch_q [$];
   data_rsp_t  exp_data_q [$];

   // Credits spent and returned since reset
   int fetch_used;
   int fetch_ret;
   int data_used;
   int data_ret;

   int    errors;
   int    checks;
   int    tests;
   int    test_err0;
   string cur_test;

   banked_mem_top i_banked_mem_top (
      .clk             (clk),
      .rst             (rst),
      .fetch_req_valid (fetch_req_valid),
      .fetch_req       (fetch_req),
      .data_req_valid  (data_req_valid),
      .data_req        (data_req),
      .fetch_rsp_valid (fetch_rsp_valid),
      .fetch_rsp       (fetch_rsp),
      .data_rsp_valid  (data_rsp_valid),
      .data_rsp        (data_rsp),
      .fetch_take      (fetch_take),
      .data_take       (data_take),
      .fetch_credit    (fetch_credit),
      .data_credit     (data_credit)
   );

   // 100 ns period
   always #50 clk = ~clk;

   // Credit pulses counted on the rising edge
   always @(posedge clk) begin
      if (!rst) begin
         if (fetch_credit) fetch_ret++;
         if (data_credit) data_ret++;
      end
   end

   //**************************************************
   // Reporting
   //**************************************************
   task automatic abort_run(input string why);
      errors++;
      $display("%s: %s", cur_test, why);
      $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic check_line(input string what, input fetch_rsp_t exp, input fetch_rsp_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp.line, act.line);
      end
   endtask

   task automatic check_data(input string what, input data_rsp_t exp, input data_rsp_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s %s: expected %h ack %b, actual %h ack %b", cur_test, what,
                  exp.rdata, exp.store_ack, act.rdata, act.store_ack);
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_err0 = errors;
      tests++;
   endtask

   task automatic finish_test();
      $display("test %-20s errors %0d", cur_test, errors - test_err0);
   endtask

   //**************************************************
   // Reference model
   //**************************************************
   // Little-endian line at the 16-byte boundary
   function automatic fetch_rsp_t model_line(input int addr);
      fetch_rsp_t r;
      int         a;
      a = addr & ~(LINE_BYTES - 1);
      for (int i = 0; i < LINE_BYTES; i++) r.line[8*i +: 8] = model[a + i];
      return r;
   endfunction

   // Sized field at the aligned address and its extension
   function automatic logic [63:0] model_load(input int addr, input acc_size_t size,
                                              input logic uns);
      logic [63:0] v;
      int          n;
      int          a;
      n = 1 << int'(size);
      a = addr & ~(n - 1);
      v = '0;
      for (int i = 0; i < n; i++) v[8*i +: 8] = model[a + i];
      if (!uns && v[8*n-1]) begin
         for (int i = 8 * n; i < 64; i++) v[i] = 1'b1;
      end
      return v;
   endfunction

   function automatic int fetch_avail();
      return CREDITS - fetch_used + fetch_ret;
   endfunction

   function automatic int data_avail();
      return CREDITS - data_used + data_ret;
   endfunction

   // Four banks twice over at two index values
   function automatic int line_addr(input int i);
      return i * LINE_BYTES + (i / 4) * 12'h200;
   endfunction

   //**************************************************
   // Host side drivers called on a falling edge
   //**************************************************
   task automatic reset_dut();
      rst             = 1'b1;
      fetch_req_valid = 1'b0;
      data_req_valid  = 1'b0;
      fetch_req       = '0;
      data_req        = '0;
      fetch_take      = 1'b0;
      data_take       = 1'b0;
      repeat (2) @(negedge clk);
      rst        = 1'b0;
      fetch_used = 0;
      fetch_ret  = 0;
      data_used  = 0;
      data_ret   = 0;
      exp_fetch_q.delete();
      exp_data_q.delete();
   endtask

   task automatic issue_fetch(input int addr);
      int n;
      n = 0;
      while (fetch_avail() == 0 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (fetch_avail() == 0) begin
         abort_run("no fetch credit came back");
      end else begin
         fetch_req_valid = 1'b1;
         fetch_req.addr  = ADDR_W'(addr);
         fetch_used++;
         exp_fetch_q.push_back(model_line(addr));
      end
   endtask

   task automatic issue_data(input int addr, input acc_size_t size, input logic uns,
                             input logic store, input logic [63:0] wdata);
      data_rsp_t exp_rsp;
      int        n;
      int        a;
      n = 0;
      while (data_avail() == 0 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (data_avail() == 0) begin
         abort_run("no data credit came back");
      end else begin
         data_req_valid       = 1'b1;
         data_req.addr        = ADDR_W'(addr);
         data_req.size        = size;
         data_req.is_unsigned = uns;
         data_req.store       = store;
         data_req.wdata       = wdata;
         data_used++;
         if (store) begin
            // Store covers the size-aligned bytes
            a = addr & ~((1 << int'(size)) - 1);
            for (int i = 0; i < (1 << int'(size)); i++) model[a + i] = wdata[8*i +: 8];
            exp_rsp.rdata     = '0;
            exp_rsp.store_ack = 1'b1;
         end else begin
            exp_rsp.rdata     = model_load(addr, size, uns);
            exp_rsp.store_ack = 1'b0;
         end
         exp_data_q.push_back(exp_rsp);
      end
   endtask

   // Requests last one cycle
   task automatic step();
      @(negedge clk);
      fetch_req_valid = 1'b0;
      data_req_valid  = 1'b0;
   endtask

   task automatic recv_fetch(input string what);
      fetch_rsp_t got;
      int         n;
      int         r0;
      n = 0;
      while (!fetch_rsp_valid && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!fetch_rsp_valid) begin
         abort_run("timed out waiting for a fetch response");
      end else if (exp_fetch_q.size() == 0) begin
         abort_run("fetch response with no request pending");
      end else begin
         got = fetch_rsp;
         check_line(what, exp_fetch_q.pop_front(), got);
         r0         = fetch_ret;
         fetch_take = 1'b1;
         @(negedge clk);
         fetch_take = 1'b0;
         n = 0;
         while (fetch_ret == r0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
         end
         if (fetch_ret == r0) begin
            abort_run("no fetch credit after a take");
         end
      end
   endtask

   task automatic recv_data(input string what);
      data_rsp_t got;
      int        n;
      int        r0;
      n = 0;
      while (!data_rsp_valid && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!data_rsp_valid) begin
         abort_run("timed out waiting for a data response");
      end else if (exp_data_q.size() == 0) begin
         abort_run("data response with no request pending");
      end else begin
         got = data_rsp;
         check_data(what, exp_data_q.pop_front(), got);
         r0        = data_ret;
         data_take = 1'b1;
         @(negedge clk);
         data_take = 1'b0;
         n = 0;
         while (data_ret == r0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
         end
         if (data_ret == r0) begin
            abort_run("no data credit after a take");
         end
      end
   endtask

   task automatic store(input int addr, input acc_size_t size, input logic [63:0] wdata);
      issue_data(addr, size, 1'b0, 1'b1, wdata);
      step();
      recv_data("store ack");
   endtask

   task automatic load(input int addr, input acc_size_t size, input logic uns);
      issue_data(addr, size, uns, 1'b0, '0);
      step();
      recv_data(uns ? "unsigned load" : "signed load");
   endtask

   //**************************************************
   // Directed tests
   //**************************************************
   task automatic store_then_fetch();
      int a;
      start_test("store_then_fetch");
      // Whole lines first so no byte stays unknown
      for (int i = 0; i < 8; i++) begin
         store(line_addr(i), SZ_DOUBLE, {$urandom, $urandom});
         store(line_addr(i) + 8, SZ_DOUBLE, {$urandom, $urandom});
      end
      // Mixed sizes at random offsets aligned down to the size
      for (int j = 0; j < 24; j++) begin
         a = line_addr($urandom % 8) + ($urandom % LINE_BYTES);
         store(a, acc_size_t'(j % 4), {$urandom, $urandom});
      end
      for (int i = 0; i < 8; i++) begin
         issue_fetch(line_addr(i) + i);
         step();
         recv_fetch("line");
      end
      finish_test();
   endtask

   task automatic load_extension();
      int          n;
      int          base;
      logic [63:0] v;
      start_test("load_extension");
      for (int s = 0; s < 4; s++) begin
         n    = 1 << s;
         base = 12'h100 + s * LINE_BYTES;
         for (int off = 0; off < LINE_BYTES; off += n) begin
            for (int neg = 0; neg < 2; neg++) begin
               v            = {$urandom, $urandom};
               v[8*n-1]     = neg[0];
               store(base + off, acc_size_t'(s), v);
               load(base + off, acc_size_t'(s), 1'b0);
               // One byte past the boundary aligns back down
               load(base + off + (n > 1), acc_size_t'(s), 1'b1);
            end
         end
      end
      finish_test();
   endtask

   task automatic concurrent_channels();
      start_test("concurrent_channels");
      // 0x090 and 0x0d0 share bank 1
      // 0x0a0 sits in bank 2
      store(12'h090, SZ_DOUBLE, {$urandom, $urandom});
      store(12'h098, SZ_DOUBLE, {$urandom, $urandom});
      store(12'h0d0, SZ_DOUBLE, {$urandom, $urandom});
      store(12'h0a8, SZ_DOUBLE, {$urandom, $urandom});
      store(12'h0a0, SZ_DOUBLE, {$urandom, $urandom});
      // Same bank in one cycle
      issue_fetch(12'h090);
      issue_data(12'h0d4, SZ_WORD, 1'b0, 1'b0, '0);
      step();
      recv_fetch("same bank line");
      recv_data("same bank load");
      // Different banks in one cycle
      issue_fetch(12'h0a0);
      issue_data(12'h09a, SZ_HALF, 1'b1, 1'b0, '0);
      step();
      recv_fetch("other bank line");
      recv_data("other bank load");
      // Fetch right behind a store to its line
      issue_data(12'h094, SZ_WORD, 1'b0, 1'b1, {$urandom, $urandom});
      step();
      issue_fetch(12'h090);
      step();
      recv_data("store ack");
      recv_fetch("line after store");
      finish_test();
   endtask

   task automatic credit_flow();
      start_test("credit_flow");
      reset_dut();
      repeat (4) @(negedge clk);
      check_count("fetch credits after reset", 0, fetch_ret);
      check_count("data credits after reset", 0, data_ret);
      // Fill both FIFOs without taking anything
      for (int i = 0; i < CREDITS; i++) begin
         issue_fetch(line_addr(i + 4));
         issue_data(line_addr(i) + 8, SZ_DOUBLE, 1'b0, 1'b0, '0);
         step();
      end
      check_count("fetch credits left", 0, fetch_avail());
      check_count("data credits left", 0, data_avail());
      repeat (8) @(negedge clk);
      check_count("fetch credits without take", 0, fetch_ret);
      check_count("data credits without take", 0, data_ret);
      check_count("fetch valid held", 1, fetch_rsp_valid);
      check_count("data valid held", 1, data_rsp_valid);
      // Queues drain in request order
      for (int i = 0; i < CREDITS; i++) begin
         recv_fetch("queued line");
         recv_data("queued load");
      end
      repeat (4) @(negedge clk);
      check_count("fetch credits returned", CREDITS, fetch_ret);
      check_count("data credits returned", CREDITS, data_ret);
      finish_test();
   endtask

   task automatic response_latency();
      int edges;
      start_test("response_latency");
      issue_fetch(line_addr(2));
      step();
      // One rising edge has sampled the request
      edges = 1;
      while (!fetch_rsp_valid && edges < TIMEOUT) begin
         @(negedge clk);
         edges++;
      end
      check_count("fetch latency", 3, edges);
      recv_fetch("line");
      issue_data(line_addr(3), SZ_DOUBLE, 1'b0, 1'b0, '0);
      step();
      edges = 1;
      while (!data_rsp_valid && edges < TIMEOUT) begin
         @(negedge clk);
         edges++;
      end
      check_count("data latency", 3, edges);
      recv_data("load");
      finish_test();
   endtask

   //**************************************************
   // Run
   //**************************************************
   initial begin
      int unsigned seed_ret;
      clk      = 1'b0;
      errors   = 0;
      checks   = 0;
      tests    = 0;
      cur_test = "reset";
      seed_ret = $urandom(32'hdf1a4bc7);
      reset_dut();
      store_then_fetch();
      load_extension();
      concurrent_channels();
      credit_flow();
      response_latency();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
logic/mem_cfg_pkg.sv
logic/mem_msg_pkg.sv
logic/mem_req_router.sv
logic/mem_bank.sv
logic/rsp_fifo.sv
logic/mem_rsp_merge.sv
logic/banked_mem_top.sv
test/banked_mem_tb.sv

// ==== Bender.yml ====
package:
  name: banked_mem

sources:
  # Packages before the modules that import them
  - logic/mem_cfg_pkg.sv
  - logic/mem_msg_pkg.sv
  - logic/mem_req_router.sv
  - logic/mem_bank.sv
  - logic/rsp_fifo.sv
  - logic/mem_rsp_merge.sv
  - logic/banked_mem_top.sv
  - target: test
    files:
      - test/banked_mem_tb.sv
